// File: sources.f
source/ecfg_regmap_pkg.sv
source/ecfg_bus_pkg.sv
source/ecfg_apb_bridge.sv
source/ecfg_rx.sv
source/ecfg_tx.sv
source/ecfg_top.sv
tests/tb_clock_gen.sv
tests/ecfg_asserts.sv
tests/ecfg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the register file testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module ecfg_tb -f sources.f -o ecfg_sim &&
./obj_dir/ecfg_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tests/ecfg_tb.sv
`timescale 1ns/1ps

module ecfg_tb;

  // ####################################################################
  // run length
  // ####################################################################
  localparam int T1_ACC       = 64;  // every index of both groups
  localparam int T2_ITER      = 40;
  localparam int T3_ITER      = 20;
  localparam int T4_ITER      = 10;
  localparam int T5_ITER      = 15;
  localparam int ACCESSES     = T1_ACC + 2 * T2_ITER + 2 * T3_ITER + 3 + T4_ITER +
                                3 * T5_ITER + 2;
  localparam int CYCLE_LIMIT  = ACCESSES * 4 + 200;  // datain waits and pulses in margin
  localparam int PREADY_LIMIT = 4;

  logic                        mi_clk;
  logic                        reset;
  ecfg_bus_pkg::apb_req_t      apb_req;
  ecfg_bus_pkg::apb_rsp_t      apb_rsp;
  ecfg_regmap_pkg::rx_datain_t rx_datain;
  ecfg_regmap_pkg::debug_t     rx_debug;
  ecfg_regmap_pkg::debug_t     tx_debug;
  ecfg_regmap_pkg::rx_cfg_t    rx_cfg;
  ecfg_regmap_pkg::tx_cfg_t    tx_cfg;

  // register model
  logic [ecfg_regmap_pkg::RX_CFG_W-1:0] rx_cfg_m = '0;
  logic [ecfg_regmap_pkg::TX_CFG_W-1:0] tx_cfg_m = '0;
  ecfg_regmap_pkg::clkdiv_t             clkdiv_m = '0;
  ecfg_regmap_pkg::debug_t              rx_dbg_m = '0;
  ecfg_regmap_pkg::debug_t              tx_dbg_m = '0;

  logic [31:0] lfsr   = 32'd1105;
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;
  int          cycles = 0;
  int          total;

  tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) clock_inst (
    .mi_clk (mi_clk),
    .reset  (reset)
  );

  ecfg_top ecfg_top_inst (
    .mi_clk    (mi_clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .rx_datain (rx_datain),
    .rx_debug  (rx_debug),
    .tx_debug  (tx_debug),
    .rx_cfg    (rx_cfg),
    .tx_cfg    (tx_cfg)
  );

  bind ecfg_apb_bridge ecfg_asserts bridge_asserts_inst (
    .mi_clk  (mi_clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always @(posedge mi_clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ####################################################################
  // random numbers and model helpers
  // ####################################################################
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;  // galois taps
    return s >> 1;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic ecfg_bus_pkg::mi_addr_t make_addr(input ecfg_regmap_pkg::group_t g,
                                                       input ecfg_regmap_pkg::reg_idx_t i);
    return {g, 9'd0, i, 2'b00};  // group in [19:16], word index in [6:2]
  endfunction

  function automatic ecfg_regmap_pkg::rx_cfg_t exp_rx_cfg();
    ecfg_regmap_pkg::rx_cfg_t c;
    c.enable     = rx_cfg_m[0];
    c.mmu_enable = rx_cfg_m[1];
    return c;
  endfunction

  function automatic ecfg_regmap_pkg::tx_cfg_t exp_tx_cfg();
    ecfg_regmap_pkg::tx_cfg_t c;
    c.enable     = tx_cfg_m[0];
    c.mmu_enable = tx_cfg_m[1];
    c.ctrl_mode  = tx_cfg_m[5:2];
    c.clkdiv     = clkdiv_m;  // lives in its own register
    return c;
  endfunction

  // ####################################################################
  // compare tasks
  // ####################################################################
  task automatic check_data(input string name, input ecfg_bus_pkg::mi_data_t got,
                            input ecfg_bus_pkg::mi_data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic check_cfg(input ecfg_regmap_pkg::rx_cfg_t rx_got,
                           input ecfg_regmap_pkg::rx_cfg_t rx_exp,
                           input ecfg_regmap_pkg::tx_cfg_t tx_got,
                           input ecfg_regmap_pkg::tx_cfg_t tx_exp);
    checks++;
    if (rx_got !== rx_exp)
    begin
      errors++;
      $display("Mismatch rx_cfg: got %h expected %h", rx_got, rx_exp);
    end
    if (tx_got !== tx_exp)
    begin
      errors++;
      $display("Mismatch tx_cfg: got %h expected %h", tx_got, tx_exp);
    end
  endtask

  task automatic compare_ports();
    @(negedge mi_clk);  // away from the edge that updates the registers
    check_cfg(rx_cfg, exp_rx_cfg(), tx_cfg, exp_tx_cfg());
  endtask

  // ####################################################################
  // apb master
  // ####################################################################

  // setup cycle, then access cycles counted until pready
  task automatic apb_access(input logic write, input ecfg_bus_pkg::mi_addr_t addr,
                            input ecfg_bus_pkg::mi_data_t wdata,
                            output ecfg_bus_pkg::mi_data_t rdata);
    int n;
    bit done;
    n     = 0;
    done  = 1'b0;
    rdata = '0;
    @(posedge mi_clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge mi_clk);
    apb_req.penable <= 1'b1;
    while (!done && n < PREADY_LIMIT)
    begin
      @(negedge mi_clk);
      n++;
      if (apb_rsp.pready)
      begin
        done  = 1'b1;
        rdata = apb_rsp.prdata;
      end
    end
    @(posedge mi_clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    checks++;
    if (!done)
    begin
      errors++;
      $display("access to %05h got no pready within %0d cycles", addr, PREADY_LIMIT);
    end
    else if (n != (write ? 1 : 2))
    begin
      errors++;
      $display("access to %05h finished in %0d access cycles, expected %0d",
               addr, n, write ? 1 : 2);
    end
  endtask

  task automatic write_reg(input ecfg_bus_pkg::mi_addr_t addr,
                           input ecfg_bus_pkg::mi_data_t data);
    ecfg_bus_pkg::mi_data_t ignored;
    apb_access(1'b1, addr, data, ignored);
  endtask

  task automatic expect_read(input ecfg_bus_pkg::mi_addr_t addr,
                             input ecfg_bus_pkg::mi_data_t exp);
    ecfg_bus_pkg::mi_data_t got;
    apb_access(1'b0, addr, '0, got);
    check_data($sformatf("prdata @%05h", addr), got, exp);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - errs_before);
  endtask

  // ####################################################################
  // tests
  // ####################################################################
  task automatic reset_values();
    int e;
    e = errors;
    for (int g = 0; g < 2; g++)
      for (int i = 0; i < 32; i++)
        expect_read(make_addr(ecfg_regmap_pkg::group_t'(g), ecfg_regmap_pkg::reg_idx_t'(i)), '0);
    compare_ports();
    end_test("reset_values", e);
  endtask

  task automatic cfg_writes();
    int e;
    int sel;
    ecfg_bus_pkg::mi_data_t d;
    ecfg_bus_pkg::mi_data_t exp;
    ecfg_bus_pkg::mi_addr_t addr;
    e = errors;
    for (int n = 0; n < T2_ITER; n++)
    begin
      sel = int'(rand_bits(2) % 3);  // rx cfg, tx cfg or tx clk
      d   = rand_bits(32);
      case (sel)
        0:
        begin
          addr     = make_addr(ecfg_regmap_pkg::RX_GROUP, ecfg_regmap_pkg::REG_CFG);
          rx_cfg_m = d[ecfg_regmap_pkg::RX_CFG_W-1:0];
          exp      = ecfg_bus_pkg::mi_data_t'(rx_cfg_m);
        end
        1:
        begin
          addr     = make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_CFG);
          tx_cfg_m = d[ecfg_regmap_pkg::TX_CFG_W-1:0];
          exp      = ecfg_bus_pkg::mi_data_t'(tx_cfg_m);
        end
        default:
        begin
          addr     = make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_CLK);
          clkdiv_m = d[ecfg_regmap_pkg::CLKDIV_W-1:0];
          exp      = ecfg_bus_pkg::mi_data_t'(clkdiv_m);
        end
      endcase
      write_reg(addr, d);
      compare_ports();
      expect_read(addr, exp);
    end
    end_test("cfg_writes", e);
  endtask

  task automatic unused_space();
    int e;
    ecfg_regmap_pkg::group_t   g;
    ecfg_regmap_pkg::reg_idx_t i;
    e = errors;
    for (int n = 0; n < T3_ITER; n++)
    begin
      g = ecfg_regmap_pkg::group_t'(rand_bits(4));
      if (g <= ecfg_regmap_pkg::TX_GROUP)
        i = ecfg_regmap_pkg::reg_idx_t'(3 + rand_bits(5) % 29);  // past REG_DEBUG
      else
        i = ecfg_regmap_pkg::reg_idx_t'(rand_bits(5));  // any index, foreign group
      write_reg(make_addr(g, i), rand_bits(32));
      expect_read(make_addr(g, i), '0);
    end
    // live registers untouched
    expect_read(make_addr(ecfg_regmap_pkg::RX_GROUP, ecfg_regmap_pkg::REG_CFG),
                ecfg_bus_pkg::mi_data_t'(rx_cfg_m));
    expect_read(make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_CFG),
                ecfg_bus_pkg::mi_data_t'(tx_cfg_m));
    expect_read(make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_CLK),
                ecfg_bus_pkg::mi_data_t'(clkdiv_m));
    compare_ports();
    end_test("unused_space", e);
  endtask

  task automatic datain_sync();
    int e;
    ecfg_regmap_pkg::rx_datain_t v;
    e = errors;
    for (int n = 0; n < T4_ITER; n++)
    begin
      v = ecfg_regmap_pkg::rx_datain_t'(rand_bits(9));
      @(posedge mi_clk);
      rx_datain <= v;
      repeat (3) @(posedge mi_clk);  // two sync stages plus slack
      expect_read(make_addr(ecfg_regmap_pkg::RX_GROUP, ecfg_regmap_pkg::REG_DATAIN),
                  ecfg_bus_pkg::mi_data_t'(v));
    end
    end_test("datain_sync", e);
  endtask

  task automatic debug_flags();
    int e;
    ecfg_regmap_pkg::debug_t p_rx;
    ecfg_regmap_pkg::debug_t p_tx;
    ecfg_bus_pkg::mi_data_t  clr;
    e = errors;
    for (int n = 0; n < T5_ITER; n++)
    begin
      p_rx = ecfg_regmap_pkg::debug_t'(rand_bits(3));
      p_tx = ecfg_regmap_pkg::debug_t'(rand_bits(3));
      @(posedge mi_clk);
      rx_debug <= p_rx;
      tx_debug <= p_tx;
      @(posedge mi_clk);
      rx_debug <= '0;  // one cycle pulse
      tx_debug <= '0;
      rx_dbg_m = rx_dbg_m | p_rx;
      tx_dbg_m = tx_dbg_m | p_tx;
      expect_read(make_addr(ecfg_regmap_pkg::RX_GROUP, ecfg_regmap_pkg::REG_DEBUG),
                  ecfg_bus_pkg::mi_data_t'(rx_dbg_m));
      expect_read(make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_DEBUG),
                  ecfg_bus_pkg::mi_data_t'(tx_dbg_m));
      clr = rand_bits(32);
      if (rand_bits(1) == 32'd1)
      begin
        write_reg(make_addr(ecfg_regmap_pkg::RX_GROUP, ecfg_regmap_pkg::REG_DEBUG), clr);
        rx_dbg_m = rx_dbg_m & ~clr[ecfg_regmap_pkg::DEBUG_W-1:0];
      end
      else
      begin
        write_reg(make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_DEBUG), clr);
        tx_dbg_m = tx_dbg_m & ~clr[ecfg_regmap_pkg::DEBUG_W-1:0];
      end
    end
    // last clear shows up here
    expect_read(make_addr(ecfg_regmap_pkg::RX_GROUP, ecfg_regmap_pkg::REG_DEBUG),
                ecfg_bus_pkg::mi_data_t'(rx_dbg_m));
    expect_read(make_addr(ecfg_regmap_pkg::TX_GROUP, ecfg_regmap_pkg::REG_DEBUG),
                ecfg_bus_pkg::mi_data_t'(tx_dbg_m));
    end_test("debug_flags", e);
  endtask

  // ####################################################################
  // main sequence
  // ####################################################################
  initial
  begin
    apb_req   = '0;
    rx_datain = '0;
    rx_debug  = '0;
    tx_debug  = '0;
    @(negedge reset);
    @(posedge mi_clk);
    reset_values();
    cfg_writes();
    unused_space();
    datain_sync();
    debug_flags();
    total = errors + ecfg_top_inst.ecfg_apb_bridge_inst.bridge_asserts_inst.assert_fails;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, total);
    if (total == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: tests/ecfg_asserts.sv
`timescale 1ns/1ps

module ecfg_asserts (
  input logic                   mi_clk,
  input logic                   reset,
  input ecfg_bus_pkg::apb_req_t apb_req,
  input ecfg_bus_pkg::apb_rsp_t apb_rsp
);

  int assert_fails = 0;  // read by the testbench at the end

  // ####################################################################
  // apb response
  // ####################################################################

  // the master drops penable on the edge that sees pready
  pready_single: assert property (@(posedge mi_clk) disable iff (reset)
    apb_rsp.pready |=> !apb_rsp.pready)
  else
  begin
    assert_fails++;
    $error("pready stayed high for more than one cycle");
  end

  // no access in flight straight out of reset
  reset_quiet: assert property (@(posedge mi_clk)
    reset |=> (!apb_rsp.pready && apb_rsp.prdata == '0))
  else
  begin
    assert_fails++;
    $error("pready or prdata not cleared by reset");
  end

  penable_in_psel: assert property (@(posedge mi_clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel)
  else
  begin
    assert_fails++;
    $error("penable seen without psel");
  end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic mi_clk,
  output logic reset
);

  initial
  begin
    mi_clk = 1'b0;
    forever #(PERIOD_NS / 2) mi_clk = ~mi_clk;  // 2 ns half period
  end

  // reset released on an edge, like any other stimulus
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge mi_clk);
    reset <= 1'b0;
  end

endmodule

// File: source/ecfg_top.sv
`timescale 1ns/1ps

module ecfg_top (
  input  logic                        mi_clk,
  input  logic                        reset,
  input  ecfg_bus_pkg::apb_req_t      apb_req,
  output ecfg_bus_pkg::apb_rsp_t      apb_rsp,
  input  ecfg_regmap_pkg::rx_datain_t rx_datain,
  input  ecfg_regmap_pkg::debug_t     rx_debug,
  input  ecfg_regmap_pkg::debug_t     tx_debug,
  output ecfg_regmap_pkg::rx_cfg_t    rx_cfg,
  output ecfg_regmap_pkg::tx_cfg_t    tx_cfg
);

  ecfg_bus_pkg::mi_req_t  mi_req;   // shared by both blocks
  ecfg_bus_pkg::mi_data_t rx_dout;
  ecfg_bus_pkg::mi_data_t tx_dout;

  // ####################################################################
  // apb slave
  // ####################################################################
  ecfg_apb_bridge ecfg_apb_bridge_inst (
    .mi_clk  (mi_clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mi_req  (mi_req),
    .rx_dout (rx_dout),
    .tx_dout (tx_dout)
  );

  // ####################################################################
  // register blocks
  // ####################################################################

  // group 0
  ecfg_rx #(
    .GROUP (ecfg_regmap_pkg::RX_GROUP)
  ) ecfg_rx_inst (
    .mi_clk    (mi_clk),
    .reset     (reset),
    .mi_req    (mi_req),
    .mi_dout   (rx_dout),
    .rx_datain (rx_datain),
    .rx_debug  (rx_debug),
    .rx_cfg    (rx_cfg)
  );

  // group 1
  ecfg_tx #(
    .GROUP (ecfg_regmap_pkg::TX_GROUP)
  ) ecfg_tx_inst (
    .mi_clk   (mi_clk),
    .reset    (reset),
    .mi_req   (mi_req),
    .mi_dout  (tx_dout),
    .tx_debug (tx_debug),
    .tx_cfg   (tx_cfg)
  );

endmodule

// File: source/ecfg_tx.sv
`timescale 1ns/1ps

module ecfg_tx #(
  parameter ecfg_regmap_pkg::group_t GROUP = ecfg_regmap_pkg::TX_GROUP
) (
  input  logic                     mi_clk,
  input  logic                     reset,
  input  ecfg_bus_pkg::mi_req_t    mi_req,
  output ecfg_bus_pkg::mi_data_t   mi_dout,
  input  ecfg_regmap_pkg::debug_t  tx_debug,   // single cycle pulses
  output ecfg_regmap_pkg::tx_cfg_t tx_cfg
);

  ecfg_regmap_pkg::group_t   group;
  ecfg_regmap_pkg::reg_idx_t idx;

  logic [ecfg_regmap_pkg::TX_CFG_W-1:0] cfg_reg;    // {ctrl_mode, mmu, enable}
  ecfg_regmap_pkg::clkdiv_t             clkdiv_reg;
  ecfg_regmap_pkg::debug_t              debug_reg;
  ecfg_regmap_pkg::debug_t              debug_clr;

  logic hit;
  logic tx_read;
  logic cfg_write;
  logic clk_write;
  logic debug_write;

  // ####################################################################
  // address decode
  // ####################################################################
  assign group = mi_req.addr[ecfg_regmap_pkg::GROUP_LSB +: ecfg_regmap_pkg::GROUP_W];
  assign idx   = mi_req.addr[ecfg_regmap_pkg::RFAW+1:2];
  assign hit   = mi_req.en & (group == GROUP);

  assign tx_read     = mi_req.en & ~mi_req.we;
  assign cfg_write   = hit & mi_req.we & (idx == ecfg_regmap_pkg::REG_CFG);
  assign clk_write   = hit & mi_req.we & (idx == ecfg_regmap_pkg::REG_CLK);
  assign debug_write = hit & mi_req.we & (idx == ecfg_regmap_pkg::REG_DEBUG);

  // ####################################################################
  // config and clock divider
  // ####################################################################
  always_ff @(posedge mi_clk)
  begin
    if (reset)
    begin
      cfg_reg    <= '0;
      clkdiv_reg <= '0;
    end
    else
    begin
      if (cfg_write)
        cfg_reg <= mi_req.din[ecfg_regmap_pkg::TX_CFG_W-1:0];
      if (clk_write)
        clkdiv_reg <= mi_req.din[ecfg_regmap_pkg::CLKDIV_W-1:0];  // divider in [3:0]
    end
  end

  // field map out of the config register
  assign tx_cfg.enable     = cfg_reg[0];
  assign tx_cfg.mmu_enable = cfg_reg[1];
  assign tx_cfg.ctrl_mode  = cfg_reg[5:2];
  assign tx_cfg.clkdiv     = clkdiv_reg;

  // sticky tx flags, write ones to clear
  assign debug_clr = debug_write ? mi_req.din[ecfg_regmap_pkg::DEBUG_W-1:0] : '0;

  always_ff @(posedge mi_clk)
  begin
    if (reset)
      debug_reg <= '0;
    else
      debug_reg <= (debug_reg & ~debug_clr) | tx_debug;  // new pulse beats clear
  end

  // ####################################################################
  // readback
  // ####################################################################

  // zero when the read belongs to someone else, bridge ORs the buses
  always_ff @(posedge mi_clk)
  begin
    if (reset)
      mi_dout <= '0;
    else if (tx_read)
    begin
      if (group != GROUP)
        mi_dout <= '0;
      else
        case (idx)
          ecfg_regmap_pkg::REG_CFG:   mi_dout <= ecfg_bus_pkg::mi_data_t'(cfg_reg);
          ecfg_regmap_pkg::REG_CLK:   mi_dout <= ecfg_bus_pkg::mi_data_t'(clkdiv_reg);
          ecfg_regmap_pkg::REG_DEBUG: mi_dout <= ecfg_bus_pkg::mi_data_t'(debug_reg);
          default:                    mi_dout <= '0;   // unused index
        endcase
    end
  end

endmodule

// File: source/ecfg_rx.sv
`timescale 1ns/1ps

module ecfg_rx #(
  parameter ecfg_regmap_pkg::group_t GROUP = ecfg_regmap_pkg::RX_GROUP
) (
  input  logic                        mi_clk,
  input  logic                        reset,
  input  ecfg_bus_pkg::mi_req_t       mi_req,
  output ecfg_bus_pkg::mi_data_t      mi_dout,
  input  ecfg_regmap_pkg::rx_datain_t rx_datain,  // frame and data pins
  input  ecfg_regmap_pkg::debug_t     rx_debug,   // single cycle pulses
  output ecfg_regmap_pkg::rx_cfg_t    rx_cfg
);

  ecfg_regmap_pkg::group_t   group;
  ecfg_regmap_pkg::reg_idx_t idx;

  logic [ecfg_regmap_pkg::RX_CFG_W-1:0] cfg_reg;
  ecfg_regmap_pkg::rx_datain_t          datain_sync;  // first stage
  ecfg_regmap_pkg::rx_datain_t          datain_reg;   // second stage
  ecfg_regmap_pkg::debug_t              debug_reg;
  ecfg_regmap_pkg::debug_t              debug_clr;

  logic hit;
  logic rx_read;
  logic cfg_write;
  logic debug_write;

  // ####################################################################
  // address decode
  // ####################################################################
  assign group = mi_req.addr[ecfg_regmap_pkg::GROUP_LSB +: ecfg_regmap_pkg::GROUP_W];
  assign idx   = mi_req.addr[ecfg_regmap_pkg::RFAW+1:2];   // word index
  assign hit   = mi_req.en & (group == GROUP);

  assign rx_read     = mi_req.en & ~mi_req.we;            // any group, clears dout
  assign cfg_write   = hit & mi_req.we & (idx == ecfg_regmap_pkg::REG_CFG);
  assign debug_write = hit & mi_req.we & (idx == ecfg_regmap_pkg::REG_DEBUG);

  // ####################################################################
  // config register
  // ####################################################################
  always_ff @(posedge mi_clk)
  begin
    if (reset)
      cfg_reg <= '0;
    else if (cfg_write)
      cfg_reg <= mi_req.din[ecfg_regmap_pkg::RX_CFG_W-1:0];
  end

  assign rx_cfg.enable     = cfg_reg[0];
  assign rx_cfg.mmu_enable = cfg_reg[1];  // upper bits only read back

  // pins are async to mi_clk, two flops before use
  always_ff @(posedge mi_clk)
  begin
    if (reset)
    begin
      datain_sync <= '0;
      datain_reg  <= '0;
    end
    else
    begin
      datain_sync <= rx_datain;
      datain_reg  <= datain_sync;
    end
  end

  // sticky debug flags, a pulse wins over a clear in the same cycle
  assign debug_clr = debug_write ? mi_req.din[ecfg_regmap_pkg::DEBUG_W-1:0] : '0;

  always_ff @(posedge mi_clk)
  begin
    if (reset)
      debug_reg <= '0;
    else
      debug_reg <= (debug_reg & ~debug_clr) | rx_debug;
  end

  // ####################################################################
  // readback, one cycle latency
  // ####################################################################
  always_ff @(posedge mi_clk)
  begin
    if (reset)
      mi_dout <= '0;
    else if (rx_read)
    begin
      if (group != GROUP)
        mi_dout <= '0;                    // other group, stay off the OR
      else
        case (idx)
          ecfg_regmap_pkg::REG_CFG:    mi_dout <= ecfg_bus_pkg::mi_data_t'(cfg_reg);
          ecfg_regmap_pkg::REG_DATAIN: mi_dout <= ecfg_bus_pkg::mi_data_t'(datain_reg);
          ecfg_regmap_pkg::REG_DEBUG:  mi_dout <= ecfg_bus_pkg::mi_data_t'(debug_reg);
          default:                     mi_dout <= '0;
        endcase
    end
  end

endmodule

// File: source/ecfg_apb_bridge.sv
`timescale 1ns/1ps

module ecfg_apb_bridge (
  input  logic                   mi_clk,
  input  logic                   reset,
  input  ecfg_bus_pkg::apb_req_t apb_req,
  output ecfg_bus_pkg::apb_rsp_t apb_rsp,
  output ecfg_bus_pkg::mi_req_t  mi_req,
  input  ecfg_bus_pkg::mi_data_t rx_dout,
  input  ecfg_bus_pkg::mi_data_t tx_dout
);

  ecfg_bus_pkg::bridge_state_t state;
  ecfg_bus_pkg::bridge_state_t state_next;

  logic access;      // first access cycle, accepted
  logic wr_access;
  logic rd_access;
  logic read_done;   // second cycle of a read

  // ####################################################################
  // access decode
  // ####################################################################

  // a new request is only taken while idle, so at most one in flight
  assign access    = apb_req.psel & apb_req.penable &
                     (state == ecfg_bus_pkg::ST_IDLE);
  assign wr_access = access & apb_req.pwrite;
  assign rd_access = access & ~apb_req.pwrite;
  assign read_done = (state == ecfg_bus_pkg::ST_READ_WAIT);

  // ####################################################################
  // state machine
  // ####################################################################
  always_comb
  begin
    state_next = state;
    case (state)
      ecfg_bus_pkg::ST_IDLE:
      begin
        if (rd_access)
        begin
          state_next = ecfg_bus_pkg::ST_READ_WAIT; // hold pready one cycle
        end
      end
      ecfg_bus_pkg::ST_READ_WAIT:
      begin
        state_next = ecfg_bus_pkg::ST_IDLE;        // dout valid now
      end
      default:
      begin
        state_next = ecfg_bus_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge mi_clk)
  begin
    if (reset)
    begin
      state <= ecfg_bus_pkg::ST_IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  // ####################################################################
  // memory interface request
  // ####################################################################

  // single cycle strobe, both blocks see the same request
  assign mi_req.en   = access;
  assign mi_req.we   = wr_access;
  assign mi_req.addr = apb_req.paddr;
  assign mi_req.din  = apb_req.pwdata;

  // ####################################################################
  // apb response
  // ####################################################################

  // writes finish in the first access cycle, reads in the second
  assign apb_rsp.pready = wr_access | read_done;

  // blocks not owning the address return zero, so OR is enough
  assign apb_rsp.prdata = rx_dout | tx_dout;

endmodule

// File: source/ecfg_bus_pkg.sv
package ecfg_bus_pkg;

  // ####################################################################
  // memory interface
  // ####################################################################
  localparam int MI_ADDR_W = 20;  // full physical address, no shifting
  localparam int MI_DATA_W = 32;  // word access only

  typedef logic [MI_ADDR_W-1:0] mi_addr_t;
  typedef logic [MI_DATA_W-1:0] mi_data_t;

  typedef struct packed {
    logic     en;    // one cycle per access
    logic     we;
    mi_addr_t addr;
    mi_data_t din;
  } mi_req_t;

  // ####################################################################
  // apb slave side
  // ####################################################################
  typedef struct packed {
    logic     psel;
    logic     penable;
    logic     pwrite;
    mi_addr_t paddr;
    mi_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    mi_data_t prdata;
    logic     pready;
  } apb_rsp_t;

  typedef enum logic [0:0] {
    ST_IDLE,       // waiting for access phase
    ST_READ_WAIT   // mi_dout lands at the next edge
  } bridge_state_t;

endpackage

// File: source/ecfg_regmap_pkg.sv
package ecfg_regmap_pkg;

  // ####################################################################
  // field widths
  // ####################################################################
  localparam int RFAW        = 5;   // 32 registers per group
  localparam int GROUP_W     = 4;
  localparam int GROUP_LSB   = 16;  // group lives in addr[19:16]
  localparam int DATAIN_W    = 9;   // frame + data pins
  localparam int DEBUG_W     = 3;
  localparam int CTRL_MODE_W = 4;
  localparam int CLKDIV_W    = 4;
  localparam int RX_CFG_W    = 5;   // rx config reg, only [1:0] leave the block
  localparam int TX_CFG_W    = 6;   // enable, mmu_enable, ctrl_mode

  typedef logic [GROUP_W-1:0]     group_t;
  typedef logic [RFAW-1:0]        reg_idx_t;
  typedef logic [DATAIN_W-1:0]    rx_datain_t;
  typedef logic [DEBUG_W-1:0]     debug_t;
  typedef logic [CTRL_MODE_W-1:0] ctrl_mode_t;
  typedef logic [CLKDIV_W-1:0]    clkdiv_t;

  // ####################################################################
  // groups and register indices
  // ####################################################################
  localparam group_t RX_GROUP = 4'h0;
  localparam group_t TX_GROUP = 4'h1;

  localparam reg_idx_t REG_CFG    = 5'd0;
  localparam reg_idx_t REG_DATAIN = 5'd1;        // sync pins in rx
  localparam reg_idx_t REG_CLK    = REG_DATAIN;  // same slot holds clkdiv in tx
  localparam reg_idx_t REG_DEBUG  = 5'd2;        // sticky flags, write-one-clear

  // enable sits in bit 0, matches the config register layout
  typedef struct packed {
    logic mmu_enable;
    logic enable;
  } rx_cfg_t;

  typedef struct packed {
    clkdiv_t    clkdiv;     // from REG_CLK
    ctrl_mode_t ctrl_mode;  // cfg[5:2]
    logic       mmu_enable; // cfg[1]
    logic       enable;     // cfg[0]
  } tx_cfg_t;

endpackage
